/* src/sa_pkg.sv */
package sa_pkg;

    localparam int ARR_H     = 4;
    localparam int ARR_W     = 4;
    localparam int MAX_LEN   = 8;
    localparam int IN_W      = 8;
    localparam int ACC_W     = 24;
    localparam int SEQ_CNT_W = 5;    // Holds MAX_LEN+2*ARR_H+ARR_W+1

    localparam logic [11:0] ADDR_CTRL   = 12'h000;
    localparam logic [11:0] ADDR_STATUS = 12'h004;
    localparam logic [11:0] ADDR_LEN    = 12'h008;
    localparam logic [11:0] ADDR_A_BASE = 12'h100;
    localparam logic [11:0] ADDR_B_BASE = 12'h200;
    localparam logic [11:0] ADDR_C_BASE = 12'h300;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef logic signed [IN_W-1:0]  op_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [3:0]              len_t;

    typedef struct packed {
        logic en;
        logic clr;
        op_t  data;
    } lane_t;

    typedef struct packed {
        logic en;
        logic clr;
        acc_t data;
    } drain_t;

    typedef op_t  [ARR_H*MAX_LEN-1:0] a_buf_t;    // Word h*MAX_LEN+k
    typedef op_t  [MAX_LEN*ARR_W-1:0] b_buf_t;    // Word k*ARR_W+w
    typedef acc_t [ARR_H*ARR_W-1:0]   c_buf_t;    // Word h*ARR_W+w
    typedef acc_t [ARR_W-1:0]         acc_row_t;

endpackage

/* src/pe_cell.sv */
`timescale 1ns/100ps

module pe_cell
    import sa_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n_i,
    input  lane_t  in_i,
    input  lane_t  wt_i,
    output lane_t  in_o,
    output lane_t  wt_o,
    input  drain_t dr_i,
    output drain_t dr_o
);

    logic [1:0]               in_ctl_q;    // {en, clr}
    logic [1:0]               wt_ctl_q;
    op_t                      in_data_q;
    op_t                      wt_data_q;
    logic signed [2*IN_W-1:0] prod;
    acc_t                     acc_q;
    acc_t                     drain_q;

    assign prod = in_i.data * wt_i.data;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_ctl_q <= 2'b00;
            wt_ctl_q <= 2'b00;
        end else begin
            in_ctl_q <= {in_i.en, in_i.clr};
            wt_ctl_q <= {wt_i.en, wt_i.clr};
        end
    end

    always_ff @(posedge clk) begin
        in_data_q <= in_i.data;
        wt_data_q <= wt_i.data;
        if (in_i.en) begin
            acc_q <= in_i.clr ? acc_t'(prod) : acc_q + acc_t'(prod);    // Wraps at ACC_W
        end
        if (dr_i.clr) begin
            drain_q <= acc_q;    // Snapshot of finished sum
        end else if (dr_i.en) begin
            drain_q <= dr_i.data;    // Shift up one row
        end
    end

    assign in_o = '{en: in_ctl_q[1], clr: in_ctl_q[0], data: in_data_q};
    assign wt_o = '{en: wt_ctl_q[1], clr: wt_ctl_q[0], data: wt_data_q};
    // Drain control reaches every row in the same cycle
    assign dr_o = '{en: dr_i.en, clr: dr_i.clr, data: drain_q};

    a_lane_en_match: assert property (@(posedge clk) disable iff (!arst_n_i)
        in_i.en == wt_i.en);

endmodule

/* src/pe_array.sv */
`timescale 1ns/100ps

module pe_array
    import sa_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  lane_t  [ARR_H-1:0]   row_i,
    input  lane_t  [ARR_W-1:0]   col_i,
    input  drain_t [ARR_W-1:0]   drain_i,
    output acc_row_t             res_o
);

    lane_t  h_link [ARR_H][ARR_W+1];    // Row links, left to right
    lane_t  v_link [ARR_H+1][ARR_W];    // Column links, top to bottom
    drain_t d_link [ARR_H+1][ARR_W];    // Drain links, bottom to top

    genvar h;
    genvar w;

    generate
        for (h = 0; h < ARR_H; h++) begin : g_row_edge
            assign h_link[h][0] = row_i[h];
        end

        for (w = 0; w < ARR_W; w++) begin : g_col_edge
            assign v_link[0][w] = col_i[w];
            assign d_link[ARR_H][w] = '{en: drain_i[w].en, clr: drain_i[w].clr, data: '0};
            assign res_o[w] = d_link[0][w].data;
        end

        for (h = 0; h < ARR_H; h++) begin : g_h
            for (w = 0; w < ARR_W; w++) begin : g_w
                pe_cell u_pe_cell (
                    .clk      (clk),
                    .arst_n_i (arst_n_i),

                    .in_i     (h_link[h][w]),
                    .in_o     (h_link[h][w+1]),

                    .wt_i     (v_link[h][w]),
                    .wt_o     (v_link[h+1][w]),

                    .dr_i     (d_link[h+1][w]),
                    .dr_o     (d_link[h][w])
                );
            end
        end
    endgenerate

endmodule

/* src/sa_regs.sv */
`timescale 1ns/100ps

module sa_regs
    import sa_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  apb_req_t   apb_i,
    output apb_rsp_t   apb_o,
    output logic       start_o,
    output len_t       len_o,
    output a_buf_t     a_o,
    output b_buf_t     b_o,
    input  logic       busy_i,
    input  logic       res_we_i,
    input  logic [1:0] res_row_i,
    input  acc_row_t   res_i
);

    logic        access;
    logic        wr;
    logic        rd;
    logic        hit_ctrl;
    logic        hit_status;
    logic        hit_len;
    logic        hit_a;
    logic        hit_b;
    logic        hit_c;
    logic        mapped;
    logic        len_ok;
    logic        start_req;
    logic        err;
    logic [4:0]  op_idx;
    logic [3:0]  c_idx;
    logic [31:0] rdata;
    len_t        len_q;
    logic        done_q;
    a_buf_t      a_q;
    b_buf_t      b_q;
    c_buf_t      c_q;

    assign access = apb_i.psel && apb_i.penable;
    assign wr     = access && apb_i.pwrite;
    assign rd     = access && !apb_i.pwrite;

    assign hit_ctrl   = apb_i.paddr == ADDR_CTRL;
    assign hit_status = apb_i.paddr == ADDR_STATUS;
    assign hit_len    = apb_i.paddr == ADDR_LEN;
    assign hit_a = (apb_i.paddr[11:7] == ADDR_A_BASE[11:7]) && (apb_i.paddr[1:0] == 2'b00);
    assign hit_b = (apb_i.paddr[11:7] == ADDR_B_BASE[11:7]) && (apb_i.paddr[1:0] == 2'b00);
    assign hit_c = (apb_i.paddr[11:6] == ADDR_C_BASE[11:6]) && (apb_i.paddr[1:0] == 2'b00);
    assign mapped = hit_ctrl || hit_status || hit_len || hit_a || hit_b || hit_c;

    assign op_idx = apb_i.paddr[6:2];
    assign c_idx  = apb_i.paddr[5:2];
    assign len_ok = (apb_i.pwdata >= 32'd1) && (apb_i.pwdata <= 32'(MAX_LEN));

    assign start_req = wr && hit_ctrl && apb_i.pwdata[0];
    assign start_o   = start_req && !busy_i;

    assign err = access && (!mapped
                 || (wr && busy_i && (hit_a || hit_b || hit_len))
                 || (wr && hit_len && !len_ok)
                 || (start_req && busy_i));

    always_comb begin
        rdata = '0;
        if (hit_status) begin
            rdata = {30'd0, done_q, busy_i};
        end else if (hit_len) begin
            rdata = {28'd0, len_q};
        end else if (hit_a) begin
            rdata = 32'(a_q[op_idx]);    // Sign-extended
        end else if (hit_b) begin
            rdata = 32'(b_q[op_idx]);
        end else if (hit_c) begin
            rdata = 32'(c_q[c_idx]);
        end
    end

    assign apb_o = '{prdata: rd ? rdata : '0, pready: 1'b1, pslverr: err};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            len_q  <= 4'd1;
            done_q <= 1'b0;
            c_q    <= '0;
        end else begin
            if (start_o) begin
                done_q <= 1'b0;
            end else if (res_we_i && (res_row_i == 2'(ARR_H-1))) begin
                done_q <= 1'b1;    // Last row lands as busy drops
            end
            if (wr && hit_len && !busy_i && len_ok) begin
                len_q <= apb_i.pwdata[3:0];
            end
            if (res_we_i) begin
                for (int w = 0; w < ARR_W; w++) begin
                    c_q[res_row_i*ARR_W + w] <= res_i[w];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && !busy_i && hit_a) begin
            a_q[op_idx] <= apb_i.pwdata[IN_W-1:0];
        end
        if (wr && !busy_i && hit_b) begin
            b_q[op_idx] <= apb_i.pwdata[IN_W-1:0];
        end
    end

    assign len_o = len_q;
    assign a_o   = a_q;
    assign b_o   = b_q;

    a_penable_in_sel: assert property (@(posedge clk) disable iff (!arst_n_i)
        apb_i.penable |-> apb_i.psel);

endmodule

/* src/sa_sequencer.sv */
`timescale 1ns/100ps

module sa_sequencer
    import sa_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  len_t                 len_i,
    input  a_buf_t               a_i,
    input  b_buf_t               b_i,
    output logic                 busy_o,
    output lane_t  [ARR_H-1:0]   row_o,
    output lane_t  [ARR_W-1:0]   col_o,
    output drain_t [ARR_W-1:0]   drain_o,
    input  acc_row_t             res_i,
    output logic                 res_we_o,
    output logic [1:0]           res_row_o,
    output acc_row_t             res_o
);

    logic                 busy_q;
    logic [SEQ_CNT_W-1:0] cnt_q;
    logic [SEQ_CNT_W-1:0] t_load;
    logic [SEQ_CNT_W-1:0] t_drn_end;
    logic [SEQ_CNT_W-1:0] t_last;
    logic                 capture;
    logic                 we_q;
    logic [1:0]           row_q;
    acc_row_t             res_q;

    assign t_load    = SEQ_CNT_W'(len_i) + SEQ_CNT_W'(ARR_H + ARR_W);    // Feed plus settle
    assign t_drn_end = t_load + SEQ_CNT_W'(ARR_H);
    assign t_last    = t_drn_end + 1'b1;
    assign capture   = busy_q && (cnt_q > t_load) && (cnt_q <= t_drn_end);

    // Skewed operand lanes
    always_comb begin
        int k;
        for (int h = 0; h < ARR_H; h++) begin
            k = int'(cnt_q) - h;
            row_o[h].en   = busy_q && (k >= 0) && (k < int'(len_i));
            row_o[h].clr  = row_o[h].en && (k == 0);
            row_o[h].data = a_i[h*MAX_LEN + int'(k[2:0])];
        end
        for (int w = 0; w < ARR_W; w++) begin
            k = int'(cnt_q) - w;
            col_o[w].en   = busy_q && (k >= 0) && (k < int'(len_i));
            col_o[w].clr  = col_o[w].en && (k == 0);
            col_o[w].data = b_i[int'(k[2:0])*ARR_W + w];
        end
        for (int w = 0; w < ARR_W; w++) begin
            drain_o[w].en   = busy_q && (cnt_q >= t_load) && (cnt_q <= t_drn_end);
            drain_o[w].clr  = busy_q && (cnt_q == t_load);
            drain_o[w].data = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            we_q   <= 1'b0;
            row_q  <= '0;
        end else begin
            we_q <= capture;
            if (capture) begin
                row_q <= 2'(cnt_q - t_load - 1'b1);
            end
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == t_last) begin
                    busy_q <= 1'b0;    // Same edge as last row strobe
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            res_q <= res_i;
        end
    end

    assign busy_o    = busy_q;
    assign res_we_o  = we_q;
    assign res_row_o = row_q;
    assign res_o     = res_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
        start_i |-> !busy_q);

endmodule

/* src/sa_top.sv */
`timescale 1ns/100ps

module sa_top
    import sa_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  apb_req_t apb_i,
    output apb_rsp_t apb_o
);

    logic                 start;
    len_t                 len;
    a_buf_t               a_buf;
    b_buf_t               b_buf;
    logic                 busy;
    logic                 res_we;
    logic [1:0]           res_row;
    acc_row_t             seq_res;
    acc_row_t             arr_res;
    lane_t  [ARR_H-1:0]   row_lane;
    lane_t  [ARR_W-1:0]   col_lane;
    drain_t [ARR_W-1:0]   drain_lane;

    sa_regs u_sa_regs (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .apb_i     (apb_i),
        .apb_o     (apb_o),
        .start_o   (start),
        .len_o     (len),
        .a_o       (a_buf),
        .b_o       (b_buf),
        .busy_i    (busy),
        .res_we_i  (res_we),
        .res_row_i (res_row),
        .res_i     (seq_res)
    );

    sa_sequencer u_sa_sequencer (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .start_i   (start),
        .len_i     (len),
        .a_i       (a_buf),
        .b_i       (b_buf),
        .busy_o    (busy),
        .row_o     (row_lane),
        .col_o     (col_lane),
        .drain_o   (drain_lane),
        .res_i     (arr_res),
        .res_we_o  (res_we),
        .res_row_o (res_row),
        .res_o     (seq_res)
    );

    pe_array u_pe_array (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .row_i    (row_lane),
        .col_i    (col_lane),
        .drain_i  (drain_lane),
        .res_o    (arr_res)
    );

endmodule

/* tb/tb_sa.sv */
`timescale 1ns/100ps

module tb_sa
    import sa_pkg::*;
;

    logic        clk;
    logic        arst_n_i;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    op_t         a_m [ARR_H][MAX_LEN];    // Model copy of A
    op_t         b_m [MAX_LEN][ARR_W];
    int          len_m;

    sa_top dut0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .apb_i    (apb_req),
        .apb_o    (apb_rsp)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [11:0] a_addr(input int h, input int k);
        return 12'(int'(ADDR_A_BASE) + (h * MAX_LEN + k) * 4);
    endfunction

    function automatic logic [11:0] b_addr(input int k, input int w);
        return 12'(int'(ADDR_B_BASE) + (k * ARR_W + w) * 4);
    endfunction

    function automatic logic [11:0] c_addr(input int h, input int w);
        return 12'(int'(ADDR_C_BASE) + (h * ARR_W + w) * 4);
    endfunction

    // Sum of products wrapped to the accumulator width
    function automatic acc_t model_c(input int h, input int w);
        int sum;
        sum = 0;
        for (int k = 0; k < len_m; k++) begin
            sum += int'(a_m[h][k]) * int'(b_m[k][w]);
        end
        return acc_t'(sum);
    endfunction

    // 0 random, 1 all -128, 2 mixed extremes
    function automatic op_t pick_op(input int mode);
        logic [31:0] r;
        if (mode == 1) begin
            return op_t'(-128);
        end
        r = next_rand();
        if (mode == 2) begin
            return r[7] ? op_t'(127) : op_t'(-128);
        end
        return op_t'(r);
    endfunction

    task automatic check_acc(input string name, input acc_t exp, input acc_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s expected %0b actual %0b", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    // Setup cycle, access cycle, response sampled mid access cycle
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #5;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #5;
        apb_req.penable = 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_flag("APB pready", 1'b1, apb_rsp.pready);
        @(posedge clk);
        #5;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
        apb_xfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic write_expect(input string name, input logic [11:0] addr,
                                input logic [31:0] data, input logic exp_err);
        logic err;
        apb_write(addr, data, err);
        check_flag({name, " pslverr"}, exp_err, err);
    endtask

    task automatic load_operands(input int len, input int mode);
        len_m = len;
        write_expect("load LEN", ADDR_LEN, 32'(len), 1'b0);
        for (int h = 0; h < ARR_H; h++) begin
            for (int k = 0; k < len; k++) begin
                a_m[h][k] = pick_op(mode);
                write_expect("load A", a_addr(h, k), 32'(a_m[h][k]), 1'b0);
            end
        end
        for (int k = 0; k < len; k++) begin
            for (int w = 0; w < ARR_W; w++) begin
                b_m[k][w] = pick_op(mode);
                write_expect("load B", b_addr(k, w), 32'(b_m[k][w]), 1'b0);
            end
        end
    endtask

    task automatic wait_done(input string name);
        logic [31:0] st;
        logic        err;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < 200) begin
            apb_read(ADDR_STATUS, st, err);
            polls++;
        end
        if (!st[1]) begin
            errors++;
            $display("%s: done never came after 200 STATUS polls", name);
        end else begin
            check_flag({name, " busy at done"}, 1'b0, st[0]);
        end
    endtask

    task automatic check_results(input string name);
        logic [31:0] d;
        logic        err;
        for (int h = 0; h < ARR_H; h++) begin
            for (int w = 0; w < ARR_W; w++) begin
                apb_read(c_addr(h, w), d, err);
                check_acc($sformatf("%s C[%0d][%0d]", name, h, w), model_c(h, w), acc_t'(d[23:0]));
                check_flag($sformatf("%s C[%0d][%0d] sext", name, h, w), 1'b1,
                           d[31:24] == {8{d[23]}});
            end
        end
    endtask

    task automatic run_and_check(input string name);
        write_expect({name, " start"}, ADDR_CTRL, 32'd1, 1'b0);
        wait_done(name);
        check_results(name);
    endtask

    initial begin
        logic [31:0] d;
        logic        err;
        clk       = 1'b0;
        arst_n_i  = 1'b0;
        apb_req   = '0;
        rng_state = 32'ha869c5d6;
        errors    = 0;
        checks    = 0;
        len_m     = 1;
        repeat (3) @(posedge clk);
        #5;
        arst_n_i = 1'b1;

        apb_read(ADDR_STATUS, d, err);
        check_flag("reset busy", 1'b0, d[0]);
        check_flag("reset done", 1'b0, d[1]);
        apb_read(c_addr(2, 3), d, err);
        check_word("reset C", 32'd0, d);

        for (int i = 0; i < 10; i++) begin
            load_operands(int'(next_rand() % 8) + 1, 0);
            if (i == 0) begin
                apb_read(ADDR_LEN, d, err);
                check_word("readback LEN", 32'(len_m), d);
                for (int k = 0; k < len_m; k++) begin
                    apb_read(a_addr(1, k), d, err);
                    check_word($sformatf("readback A[1][%0d]", k), 32'(a_m[1][k]), d);
                    apb_read(b_addr(k, 2), d, err);
                    check_word($sformatf("readback B[%0d][2]", k), 32'(b_m[k][2]), d);
                end
            end
            run_and_check($sformatf("rand%0d", i));
        end

        // Rerun on unchanged buffers
        write_expect("b2b start", ADDR_CTRL, 32'd1, 1'b0);
        apb_read(ADDR_STATUS, d, err);
        check_flag("b2b busy", 1'b1, d[0]);
        check_flag("b2b done cleared", 1'b0, d[1]);
        wait_done("b2b");
        check_results("b2b");

        load_operands(8, 1);
        run_and_check("wrap all min");
        load_operands(8, 2);
        run_and_check("wrap mixed");

        write_expect("unmapped write", 12'h00c, 32'd5, 1'b1);
        apb_read(12'h400, d, err);
        check_flag("unmapped read pslverr", 1'b1, err);
        write_expect("LEN 0", ADDR_LEN, 32'd0, 1'b1);
        write_expect("LEN 9", ADDR_LEN, 32'd9, 1'b1);
        apb_read(ADDR_LEN, d, err);
        check_word("LEN kept", 32'd8, d);

        load_operands(8, 0);
        write_expect("busy start", ADDR_CTRL, 32'd1, 1'b0);
        write_expect("A while busy", a_addr(0, 0), 32'(~a_m[0][0]), 1'b1);
        write_expect("LEN while busy", ADDR_LEN, 32'd3, 1'b1);
        write_expect("start while busy", ADDR_CTRL, 32'd1, 1'b1);
        wait_done("busy run");
        check_results("busy run");
        apb_read(a_addr(0, 0), d, err);
        check_word("A kept", 32'(a_m[0][0]), d);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
src/sa_pkg.sv
src/pe_cell.sv
src/pe_array.sv
src/sa_regs.sv
src/sa_sequencer.sv
src/sa_top.sv
tb/tb_sa.sv

/* run.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_sa -f project.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation ended without a result line, see sim.log"
    exit 1
fi
echo "Simulation passed"
